// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = gfx_tb
FILELIST  = all.f
OBJDIR    = obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: sim clean

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	out="$$(./$(OBJDIR)/V$(TOP))"; \
	status=$$?; \
	echo "$$out"; \
	test $$status -eq 0 && echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

// ==== all.f ====
+incdir+src
+incdir+verification
src/gfx_pkg.sv
src/display_timing.sv
src/fb_bram.sv
src/shape_render.sv
src/fb_control.sv
src/scan_reader.sv
src/palette_regs.sv
src/gfx_top.sv
verification/gfx_tb.sv

// ==== src/display_timing.sv ====
/* raster counters for the test mode, positive sync polarity
   syncs, de and strobes are decoded straight from the counters, no pipeline */
`include "fb_config.svh"

module display_timing import gfx_pkg::*; (
    input  wire logic clk_sys,
    input  wire logic rst_sys,
    output cord_t     sx,      // horizontal position
    output cord_t     sy,      // vertical position
    output logic      hsync,
    output logic      vsync,
    output logic      de,      // active video
    output logic      frame,   // start of frame
    output logic      line     // start of line
    );

    logic end_of_line;
    logic end_of_frame;

    always_comb begin
        end_of_line  = (sx == cord_t'(`H_TOTAL - 1));
        end_of_frame = (sy == cord_t'(`V_TOTAL - 1));
    end

    // position counters
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            sx <= '0;
            sy <= '0;
        end else if (end_of_line) begin
            sx <= '0;
            sy <= end_of_frame ? '0 : sy + 1'b1;  // wrap at bottom
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // sync and enable decode
    always_comb begin
        hsync = (sx >= `HS_START && sx < `HS_END);
        vsync = (sy >= `VS_START && sy < `VS_END);
        de    = (sx < `H_ACTIVE && sy < `V_ACTIVE);
    end

    // strobes
    always_comb begin
        line  = (sx == '0);
        frame = (sx == '0 && sy == '0);  // first cycle after reset too
    end

endmodule

// ==== src/fb_bram.sv ====
/* simple dual-port framebuffer, one write and one read port on clk_sys
   read data appears one cycle after the address, contents start undefined */
`include "fb_config.svh"

module fb_bram import gfx_pkg::*; (
    input  wire logic     clk_sys,
    input  wire logic     we,          // write enable
    input  wire fb_addr_t addr_write,
    input  wire fb_addr_t addr_read,
    input  wire cidx_t    data_in,
    output cidx_t         data_out
    );

    cidx_t mem [`FB_PIXELS];

    always_ff @(posedge clk_sys) begin
        if (we) mem[addr_write] <= data_in;
    end

    // registered read, independent of write address
    always_ff @(posedge clk_sys) begin
        data_out <= mem[addr_read];
    end

endmodule

// ==== src/fb_config.svh ====
/* raster, framebuffer and colour constants shared by the RTL and the testbench
   FB_OFFY must be at least 1 and H_TOTAL - H_ACTIVE at least FB_WIDTH */
`ifndef FB_CONFIG_SVH
`define FB_CONFIG_SVH

// reduced test raster, pixels and lines
`define H_ACTIVE 40
`define H_TOTAL 56
`define V_ACTIVE 24
`define V_TOTAL 28
`define HS_START 44   // hsync high from here
`define HS_END 48     // up to but not including
`define VS_START 25
`define VS_END 26

// framebuffer geometry
`define FB_WIDTH 16
`define FB_HEIGHT 8
`define FB_PIXELS (`FB_WIDTH * `FB_HEIGHT)
`define FB_SCALE 2    // integer display scale
`define FB_OFFX 4     // left edge of scaled buffer on screen
`define FB_OFFY 4     // top edge

// moving square
`define SQ_SIZE 4
`define SQ_Y 2
`define SQ_CIDX 3

// colours, 4 bits per channel rgb
`define BG_COLR 12'h137
`define PAL_DEF0 12'h102
`define PAL_DEF1 12'h4a8
`define PAL_DEF2 12'hc84
`define PAL_DEF3 12'hfe5

`endif

// ==== src/fb_control.sv ====
/* per-frame sequence: swap buffers, clear back buffer, draw the square
   whole sequence must fit inside one frame, write goes to the back memory only */
`include "fb_config.svh"

module fb_control import gfx_pkg::*; (
    input  wire logic  clk_sys,
    input  wire logic  rst_sys,
    input  wire logic  frame,         // frame start strobe
    input  wire logic  render_done,
    input  wire cord_t drx,           // renderer pixel
    input  wire cord_t dry,
    input  wire cidx_t render_cidx,
    input  wire logic  drawing,       // renderer pixel valid
    output logic       render_start,
    output logic       fb_front,      // 1: memory 1 is front, 0: memory 0
    output fb_addr_t   addr_write,
    output cidx_t      colr_write,
    output logic       we0,
    output logic       we1
    );

    localparam fb_addr_t LAST_ADDR = fb_addr_t'(`FB_PIXELS - 1);

    fb_state_t state;
    fb_addr_t  clr_addr;  // clear pointer
    logic      we_q;      // write enable, aligned with address stage

    // frame state machine
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state        <= IDLE;
            fb_front     <= 1'b0;
            clr_addr     <= '0;
            render_start <= 1'b0;
        end else begin
            case (state)
                IDLE: if (frame) state <= INIT;
                INIT: begin
                    state    <= CLEAR;
                    fb_front <= ~fb_front;  // last frame's drawing goes on screen
                    clr_addr <= '0;
                end
                CLEAR: begin
                    clr_addr <= clr_addr + 1'b1;
                    if (clr_addr == LAST_ADDR) begin
                        state        <= DRAW;
                        render_start <= 1'b1;
                    end
                end
                DRAW: begin
                    render_start <= 1'b0;  // single pulse
                    if (render_done) state <= DONE;
                end
                DONE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // address stage, clear has priority over render
    always_ff @(posedge clk_sys) begin
        if (state == CLEAR) begin
            addr_write <= clr_addr;
            colr_write <= '0;  // background index
        end else begin
            addr_write <= fb_addr_t'(dry * `FB_WIDTH + drx);  // row * width + col
            colr_write <= render_cidx;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            we_q <= 1'b0;
        end else begin
            we_q <= (state == CLEAR) || drawing;
        end
    end

    // steer to the memory not on screen
    always_comb begin
        we0 = we_q && fb_front;
        we1 = we_q && !fb_front;
    end

    // clear and draw must be finished before the next frame start
    assert property (@(posedge clk_sys) disable iff (rst_sys) frame |-> state == IDLE)
        else $error("frame start while controller busy, state %s", state.name());

endmodule

// ==== src/gfx_pkg.sv ====
/* types shared across the graphics subsystem
   widths here are sized for the 16x8 framebuffer in fb_config.svh */
package gfx_pkg;

    // screen and draw coordinates, unsigned
    typedef logic [7:0] cord_t;

    // framebuffer address, covers FB_PIXELS
    typedef logic [6:0] fb_addr_t;

    // colour index stored per pixel
    typedef logic [1:0] cidx_t;

    // 12-bit rgb colour
    typedef logic [11:0] colr_t;

    // frame controller states
    typedef enum logic [2:0] {
        IDLE,   // wait for frame start
        INIT,   // swap buffers
        CLEAR,  // wipe back buffer
        DRAW,   // renderer busy
        DONE
    } fb_state_t;

endpackage

// ==== src/gfx_top.sv ====
/* double-buffered framebuffer subsystem, single clock, pixel rate = clk_sys
   video outputs lag the raster counters by two cycles */
module gfx_top import gfx_pkg::*; (
    input  wire logic  clk_sys,
    input  wire logic  rst_sys,
    input  wire logic  pal_we,    // palette write port
    input  wire cidx_t pal_idx,
    input  wire colr_t pal_colr,
    output logic       hsync,
    output logic       vsync,
    output logic       de,
    output colr_t      colr
    );

    // raster
    cord_t sx, sy;
    logic  tim_hsync, tim_vsync, tim_de;
    logic  frame;

    display_timing display_timing_inst (
        .clk_sys,
        .rst_sys,
        .sx,
        .sy,
        .hsync (tim_hsync),
        .vsync (tim_vsync),
        .de    (tim_de),
        .frame,
        .line  ()  // row timing is decoded from sx in scan_reader
    );

    // drawing
    logic  render_start, render_done, drawing;
    cord_t drx, dry;
    cidx_t render_cidx;

    shape_render shape_render_inst (
        .clk_sys,
        .rst_sys,
        .start   (render_start),
        .x       (drx),
        .y       (dry),
        .cidx    (render_cidx),
        .drawing,
        .done    (render_done)
    );

    logic     fb_front;
    fb_addr_t addr_write, addr_read;
    cidx_t    colr_write;
    logic     we0, we1;

    fb_control fb_control_inst (
        .clk_sys,
        .rst_sys,
        .frame,
        .render_done,
        .drx,
        .dry,
        .render_cidx,
        .drawing,
        .render_start,
        .fb_front,
        .addr_write,
        .colr_write,
        .we0,
        .we1
    );

    // two framebuffers, same write bus, enables steered by fb_control
    cidx_t data0, data1;

    fb_bram fb_bram_inst_0 (
        .clk_sys,
        .we         (we0),
        .addr_write,
        .addr_read,
        .data_in    (colr_write),
        .data_out   (data0)
    );

    fb_bram fb_bram_inst_1 (
        .clk_sys,
        .we         (we1),
        .addr_write,
        .addr_read,
        .data_in    (colr_write),
        .data_out   (data1)
    );

    // display path
    cidx_t pix_cidx;
    logic  in_area;

    scan_reader scan_reader_inst (
        .clk_sys,
        .rst_sys,
        .sx,
        .sy,
        .fb_front,
        .data0,
        .data1,
        .addr_read,
        .pix_cidx,
        .in_area
    );

    palette_regs palette_regs_inst (
        .clk_sys,
        .rst_sys,
        .pal_we,
        .pal_idx,
        .pal_colr,
        .pix_cidx,
        .in_area,
        .de       (tim_de),
        .hsync_in (tim_hsync),
        .vsync_in (tim_vsync),
        .colr,
        .hsync,
        .vsync,
        .de_out   (de)
    );

endmodule

// ==== src/palette_regs.sv ====
/* four-entry colour lookup with reset defaults, writes land on the next cycle
   adds one stage to syncs before the final paint register, two cycles overall */
`include "fb_config.svh"

module palette_regs import gfx_pkg::*; (
    input  wire logic  clk_sys,
    input  wire logic  rst_sys,
    input  wire logic  pal_we,
    input  wire cidx_t pal_idx,
    input  wire colr_t pal_colr,
    input  wire cidx_t pix_cidx,   // one cycle after counters
    input  wire logic  in_area,
    input  wire logic  de,         // straight from counters
    input  wire logic  hsync_in,
    input  wire logic  vsync_in,
    output colr_t      colr,
    output logic       hsync,
    output logic       vsync,
    output logic       de_out
    );

    colr_t pal [4];
    logic  de_q;  // aligned with pix_cidx
    logic  hs_q;
    logic  vs_q;

    // palette registers
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            pal[0] <= `PAL_DEF0;
            pal[1] <= `PAL_DEF1;
            pal[2] <= `PAL_DEF2;
            pal[3] <= `PAL_DEF3;
        end else if (pal_we) begin
            pal[pal_idx] <= pal_colr;
        end
    end

    // sync pipeline, two stages to match colour
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            {de_q, hs_q, vs_q}        <= '0;
            {de_out, hsync, vsync}    <= '0;
        end else begin
            {de_q, hs_q, vs_q}        <= {de, hsync_in, vsync_in};
            {de_out, hsync, vsync}    <= {de_q, hs_q, vs_q};
        end
    end

    // paint: black in blanking, palette inside buffer, background elsewhere
    always_ff @(posedge clk_sys) begin
        if (!de_q) begin
            colr <= '0;
        end else if (in_area) begin
            colr <= pal[pix_cidx];
        end else begin
            colr <= `BG_COLR;
        end
    end

endmodule

// ==== src/scan_reader.sv ====
/* fetches one framebuffer row into a line buffer during the preceding hblank
   and replays it with integer scaling, output one cycle after sx/sy
   needs FB_OFFY >= 1 so the first fill line exists */
`include "fb_config.svh"

module scan_reader import gfx_pkg::*; (
    input  wire logic  clk_sys,
    input  wire logic  rst_sys,
    input  wire cord_t sx,
    input  wire cord_t sy,
    input  wire logic  fb_front,
    input  wire cidx_t data0,      // memory 0 read data
    input  wire cidx_t data1,      // memory 1 read data
    output fb_addr_t   addr_read,  // shared by both memories
    output cidx_t      pix_cidx,   // replayed index
    output logic       in_area     // pixel inside scaled buffer
    );

    localparam int LB_IW  = $clog2(`FB_WIDTH);
    localparam int AREA_W = `FB_WIDTH * `FB_SCALE;
    localparam int AREA_H = `FB_HEIGHT * `FB_SCALE;

    cidx_t lbuf [`FB_WIDTH];  // line buffer

    cord_t            next_y;      // line after the current one
    cord_t            fill_rel_y;  // its offset into the scaled area
    cord_t            fill_rel_x;  // hblank position
    cord_t            rel_x;       // replay offset
    logic             fill_line;   // next line starts a new buffer row
    logic             fill_en;     // read issued this cycle
    logic             fill_wr;     // read data valid this cycle
    logic [LB_IW-1:0] fill_col;
    logic [LB_IW-1:0] rd_idx;
    logic             in_area_c;

    // fill side
    always_comb begin
        next_y     = sy + 1'b1;
        fill_rel_y = next_y - cord_t'(`FB_OFFY);
        fill_line  = (next_y >= `FB_OFFY) && (next_y < `FB_OFFY + AREA_H)
                     && (fill_rel_y % `FB_SCALE == 0);
        fill_rel_x = sx - cord_t'(`H_ACTIVE);
        fill_en    = fill_line && (sx >= `H_ACTIVE) && (sx < `H_ACTIVE + `FB_WIDTH);
        addr_read  = fb_addr_t'((fill_rel_y / `FB_SCALE) * `FB_WIDTH + fill_rel_x);
    end

    // memory latency is one cycle, so delay the write strobe and column
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            fill_wr <= 1'b0;
        end else begin
            fill_wr <= fill_en;
        end
    end

    always_ff @(posedge clk_sys) begin
        fill_col <= fill_rel_x[LB_IW-1:0];
        if (fill_wr) lbuf[fill_col] <= fb_front ? data1 : data0;  // front buffer
    end

    // replay side
    always_comb begin
        rel_x     = sx - cord_t'(`FB_OFFX);
        rd_idx    = LB_IW'(rel_x / `FB_SCALE);  // each entry shown FB_SCALE times
        in_area_c = (sx >= `FB_OFFX) && (sx < `FB_OFFX + AREA_W)
                    && (sy >= `FB_OFFY) && (sy < `FB_OFFY + AREA_H);
    end

    always_ff @(posedge clk_sys) begin
        pix_cidx <= lbuf[rd_idx];
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            in_area <= 1'b0;
        end else begin
            in_area <= in_area_c;
        end
    end

    // hblank has to be wide enough to fetch a whole row
    assert property (@(posedge clk_sys) (`H_TOTAL - `H_ACTIVE) >= `FB_WIDTH)
        else $error("hblank narrower than framebuffer row");

endmodule

// ==== src/shape_render.sv ====
/* draws one filled square per start pulse, one pixel per cycle, row by row
   square column steps right by one per draw and wraps, no clipping is done */
`include "fb_config.svh"

module shape_render import gfx_pkg::*; (
    input  wire logic clk_sys,
    input  wire logic rst_sys,
    input  wire logic start,    // begin a square
    output cord_t     x,        // current pixel
    output cord_t     y,
    output cidx_t     cidx,     // colour of current pixel
    output logic      drawing,  // x, y, cidx valid
    output logic      done      // one-cycle pulse after last pixel
    );

    localparam int LAST_COL = `FB_WIDTH - `SQ_SIZE;  // rightmost origin

    cord_t draw_col;  // draw counter n, kept as n mod (LAST_COL+1)
    cord_t x0;        // left edge of current square
    logic  last_x;
    logic  last_y;

    always_comb begin
        last_x = (x == x0 + cord_t'(`SQ_SIZE - 1));
        last_y = (y == cord_t'(`SQ_Y + `SQ_SIZE - 1));
        cidx   = cidx_t'(`SQ_CIDX);  // solid fill
    end

    // coordinate walk
    always_ff @(posedge clk_sys) begin
        if (start) begin
            x0 <= draw_col;
            x  <= draw_col;
            y  <= cord_t'(`SQ_Y);
        end else if (drawing) begin
            if (last_x) begin
                x <= x0;          // back to left edge
                y <= y + 1'b1;    // next row
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // busy flag, done pulse and draw counter
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            drawing  <= 1'b0;
            done     <= 1'b0;
            draw_col <= '0;
        end else begin
            done <= drawing && last_x && last_y;
            if (start) begin
                drawing <= 1'b1;
            end else if (drawing && last_x && last_y) begin
                drawing <= 1'b0;
            end
            if (done) begin
                draw_col <= (draw_col == cord_t'(LAST_COL)) ? '0 : draw_col + 1'b1;
            end
        end
    end

    // controller only restarts once the previous square has finished
    assert property (@(posedge clk_sys) disable iff (rst_sys) start |-> !drawing)
        else $error("render start while drawing");

endmodule

// ==== verification/frame_model.svh ====
/* reference model of what gfx_top shows, included inside the testbench module
   frame k shows draw k-1, frame 0 is uncleared memory and has no expected picture */
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

// palette copy, follows every write the testbench drives
colr_t pal_model [4];
bit    pal_touched [4];  // entry rewritten since reset
int    pal_writes;

function automatic void reset_palette();
    pal_model[0] = `PAL_DEF0;
    pal_model[1] = `PAL_DEF1;
    pal_model[2] = `PAL_DEF2;
    pal_model[3] = `PAL_DEF3;
    for (int i = 0; i < 4; i++) begin
        pal_touched[i] = 1'b0;
    end
    pal_writes = 0;
endfunction

function automatic void note_palette_write(int idx, colr_t c);
    pal_model[idx]   = c;
    pal_touched[idx] = 1'b1;
    pal_writes++;
endfunction

// left column of draw n, wraps once the square touches the right edge
function automatic int square_col(int n);
    return n % (`FB_WIDTH - `SQ_SIZE + 1);
endfunction

// back buffer is wiped before every draw, so only draw n is left in it
function automatic int cell_index(int n, int col, int row);
    int c0;
    c0 = square_col(n);
    if (row >= `SQ_Y && row < `SQ_Y + `SQ_SIZE && col >= c0 && col < c0 + `SQ_SIZE)
        return `SQ_CIDX;
    return 0;
endfunction

// scaled framebuffer rectangle on screen
function automatic bit in_rect(int x, int y);
    return x >= `FB_OFFX && x < `FB_OFFX + `FB_WIDTH * `FB_SCALE
        && y >= `FB_OFFY && y < `FB_OFFY + `FB_HEIGHT * `FB_SCALE;
endfunction

function automatic int pixel_index(int frame_no, int x, int y);
    return cell_index(frame_no - 1, (x - `FB_OFFX) / `FB_SCALE, (y - `FB_OFFY) / `FB_SCALE);
endfunction

// expected colour of an active pixel
function automatic colr_t pixel_colr(int frame_no, int x, int y);
    if (!in_rect(x, y))
        return `BG_COLR;
    return pal_model[pixel_index(frame_no, x, y)];
endfunction

`endif

// ==== verification/gfx_tb.sv ====
/* testbench for gfx_top, 12 frames with random palette writes in vertical blanking
   screen position is rebuilt from the video outputs, sampled on the falling clock edge */
`include "fb_config.svh"

module gfx_tb import gfx_pkg::*; ();

    localparam int RUN_FRAMES   = 12;
    localparam int CLK_PERIOD   = 4;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int SQ_PIXELS    = `SQ_SIZE * `SQ_SIZE * `FB_SCALE * `FB_SCALE;
    localparam int HS_CYCLES    = `V_TOTAL * (`HS_END - `HS_START);  // hsync high per frame

    logic  clk_sys;
    logic  rst_sys;
    logic  pal_we;
    cidx_t pal_idx;
    colr_t pal_colr;
    logic  hsync;
    logic  vsync;
    logic  de;
    colr_t colr;

    `include "frame_model.svh"

    int checks [1:5];  // per behaviour
    int errors [1:5];

    // output tracker state
    int   px = 0;            // pixel within line, counted from de rise
    int   py = 0;            // active line within frame
    int   frame_no = 0;      // bumped on vsync fall
    logic de_d = 1'b0;
    logic vs_d = 1'b0;
    int   hs_count = 0;      // hsync high cycles this frame
    int   sq_count = 0;      // pixels in square colour this frame
    int   sq_min_col = `FB_WIDTH;

    gfx_top UUT (
        .clk_sys,
        .rst_sys,
        .pal_we,
        .pal_idx,
        .pal_colr,
        .hsync,
        .vsync,
        .de,
        .colr
    );

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    function automatic string behaviour_name(int b);
        case (b)
            1: return "raster shape";
            2: return "blanking and background";
            3: return "double-buffered drawing";
            4: return "movement and clear";
            default: return "palette writes";
        endcase
    endfunction

    // one active or blank pixel
    task automatic check_pixel();
        colr_t exp_c;
        int    idx;
        bit    pal_case;
        if (!de) begin
            checks[2]++;
            assert (colr == 12'h000) else begin
                $display("[FAIL] colr in blanking, frame %0d: expected 'h000, got 'h%h",
                         frame_no, colr);
                errors[2]++;
            end
        end else if (!in_rect(px, py)) begin
            checks[2]++;
            assert (colr == `BG_COLR) else begin
                $display("[FAIL] colr frame %0d x %0d y %0d: expected 'h%h, got 'h%h",
                         frame_no, px, py, `BG_COLR, colr);
                errors[2]++;
            end
        end else if (frame_no >= 1) begin  // frame 0 shows uncleared memory
            exp_c    = pixel_colr(frame_no, px, py);
            idx      = pixel_index(frame_no, px, py);
            pal_case = (pal_writes == 0) || pal_touched[idx];  // defaults or rewritten
            checks[3]++;
            if (pal_case)
                checks[5]++;
            assert (colr == exp_c) else begin
                $display("[FAIL] colr frame %0d x %0d y %0d: expected 'h%h, got 'h%h",
                         frame_no, px, py, exp_c, colr);
                errors[3]++;
                if (pal_case)
                    errors[5]++;
            end
            // square footprint, only when its colour stands out
            if (pal_model[`SQ_CIDX] != pal_model[0] && colr == pal_model[`SQ_CIDX]) begin
                sq_count++;
                if ((px - `FB_OFFX) / `FB_SCALE < sq_min_col)
                    sq_min_col = (px - `FB_OFFX) / `FB_SCALE;
            end
        end
    endtask

    task automatic finish_frame();
        checks[1]++;
        assert (py == `V_ACTIVE) else begin
            $display("[FAIL] active lines frame %0d: expected 'h%0h, got 'h%0h",
                     frame_no, `V_ACTIVE, py);
            errors[1]++;
        end
        if (frame_no >= 1) begin  // frame 0 window starts mid-raster
            checks[1]++;
            assert (hs_count == HS_CYCLES) else begin
                $display("[FAIL] hsync cycles frame %0d: expected 'h%0h, got 'h%0h",
                         frame_no, HS_CYCLES, hs_count);
                errors[1]++;
            end
        end
        if (frame_no >= 1 && pal_model[`SQ_CIDX] != pal_model[0]) begin
            checks[4]++;
            assert (sq_count == SQ_PIXELS && sq_min_col == square_col(frame_no - 1)) else begin
                // left column, then pixel count
                $display("[FAIL] square frame %0d: expected 'h%0h/'h%0h, got 'h%0h/'h%0h",
                         frame_no, square_col(frame_no - 1), SQ_PIXELS, sq_min_col, sq_count);
                errors[4]++;
            end
        end
        hs_count   = 0;
        sq_count   = 0;
        sq_min_col = `FB_WIDTH;
    endtask

    task automatic track_outputs();
        if (de && !de_d)
            px = 0;  // line start
        if (de) begin
            checks[1]++;
            assert (!hsync && !vsync) else begin
                $display("sync pulse high during active video in frame %0d line %0d",
                         frame_no, py);
                errors[1]++;
            end
        end
        if (hsync)
            hs_count++;
        check_pixel();
        if (de)
            px++;
        if (!de && de_d) begin  // line end
            checks[1]++;
            assert (px == `H_ACTIVE) else begin
                $display("[FAIL] de count frame %0d line %0d: expected 'h%0h, got 'h%0h",
                         frame_no, py, `H_ACTIVE, px);
                errors[1]++;
            end
            py++;
        end
        if (!vsync && vs_d) begin  // frame end
            finish_frame();
            py = 0;
            frame_no++;  // last, main loop keys on it
        end
        de_d = de;
        vs_d = vsync;
    endtask

    always @(negedge clk_sys) begin
        if (!rst_sys)
            track_outputs();
    end

    // a few random writes at a random point of vertical blanking
    task automatic write_palette_burst();
        int delay;
        int nwr;
        delay = $urandom_range(60);
        nwr   = $urandom_range(3, 1);
        repeat (delay) @(posedge clk_sys);
        for (int i = 0; i < nwr; i++) begin
            #1;
            pal_we   = 1'b1;
            pal_idx  = cidx_t'($urandom_range(3));
            pal_colr = colr_t'($urandom);
            note_palette_write(int'(pal_idx), pal_colr);
            @(posedge clk_sys);
        end
        #1;
        pal_we = 1'b0;
    endtask

    task automatic report_summary();
        int passed;
        int failed;
        bit ok;
        passed = 0;
        failed = 0;
        for (int b = 1; b <= 5; b++) begin
            ok = (errors[b] == 0) && (checks[b] > 0);
            $display("test %0d %s: %0d checks, %0d errors, %s", b, behaviour_name(b),
                     checks[b], errors[b], ok ? "ok" : "bad");
            if (ok)
                passed++;
            else
                failed++;
        end
        $display("tests passed %0d, tests failed %0d, palette writes %0d",
                 passed, failed, pal_writes);
        if (failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
    endtask

    initial begin
        int last_frame;
        void'($urandom(80055));
        rst_sys  = 1'b1;
        pal_we   = 1'b0;
        pal_idx  = '0;
        pal_colr = '0;
        for (int b = 1; b <= 5; b++) begin
            checks[b] = 0;
            errors[b] = 0;
        end
        reset_palette();
        repeat (3) @(posedge clk_sys);
        #1;
        rst_sys    = 1'b0;
        last_frame = 0;
        // first writes from frame 3, so early frames show the reset defaults
        while (frame_no < RUN_FRAMES) begin
            @(posedge clk_sys);
            if (frame_no != last_frame) begin
                last_frame = frame_no;
                if (frame_no >= 3 && frame_no < RUN_FRAMES)
                    write_palette_burst();
            end
        end
        report_summary();
        $finish;
    end

    // watchdog, two frames of slack over the run
    initial begin
        #(14 * FRAME_CYCLES * CLK_PERIOD);
        $display("run timed out with %0d of %0d frames seen", frame_no, RUN_FRAMES);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
